//--- common/pcs_rx_params.svh
// Fixed lock thresholds and descrambler taps for the PCS receive path.
// Include this wherever the values are needed; no module parameters exist.
`ifndef PCS_RX_PARAMS_SVH
`define PCS_RX_PARAMS_SVH

// consecutive valid sync headers needed before block lock is declared
`define PCS_LOCK_GOOD_CNT 64

// headers per monitoring window once locked
`define PCS_BAD_SH_WINDOW 64

// invalid headers within one window that drop block lock
`define PCS_BAD_SH_MAX 16

// taps of the x^58 + x^39 + 1 self-synchronizing polynomial
`define PCS_SCR_TAP_A 39
`define PCS_SCR_TAP_B 58

`endif

//--- common/pcs_rx_pkg.sv
// Shared types for the PCS receive path: the received block word, the
// control type codes, the sync header values and the XGMII lane characters.
package pcs_rx_pkg;

    // sync header values, 00 and 11 are invalid
    typedef enum logic [1:0] {
        SYNC_DATA = 2'b01,
        SYNC_CTRL = 2'b10
    } pcs_sync_e;

    // block type field of a control block
    typedef enum logic [7:0] {
        TYPE_C8    = 8'h1e,  // eight control characters
        TYPE_C4_S  = 8'h33,  // four control then start
        TYPE_S_D7  = 8'h78,  // start then seven data
        TYPE_T0    = 8'h87,  // terminate in lane 7
        TYPE_T1    = 8'h99,
        TYPE_T2    = 8'haa,
        TYPE_T3    = 8'hb4,
        TYPE_T4    = 8'hcc,
        TYPE_T5    = 8'hd2,
        TYPE_T6    = 8'he1,
        TYPE_T7    = 8'hff,  // terminate in lane 0
        TYPE_O_C4  = 8'h4b,  // ordered set then four control
        TYPE_C4_O  = 8'h2d,  // four control then ordered set
        TYPE_O_S   = 8'h66,  // ordered set then start
        TYPE_O_O   = 8'h55   // two ordered sets
    } pcs_type_e;

    // characters placed on control lanes
    typedef enum logic [7:0] {
        CHAR_IDLE  = 8'h07,
        CHAR_START = 8'hfb,
        CHAR_TERM  = 8'hfd,
        CHAR_SEQ   = 8'h9c
    } pcs_char_e;

    // control view: type byte on top of the 56-bit block payload
    typedef struct packed {
        pcs_type_e   type_code;
        logic [55:0] payload;
    } pcs_ctl_view_s;

    // one received 64-bit word, seen either as raw bytes or as a control block
    typedef union packed {
        logic [7:0][7:0] bytes;  // byte 7 is the most significant
        pcs_ctl_view_s   ctl;
    } pcs_block_u;

endpackage

//--- logic/pcs_block_lock.sv
// Block lock monitor on the received sync headers. Lock rises after a run of
// valid headers and drops when too many invalid headers land in one window.
`include "pcs_rx_params.svh"

module pcs_block_lock (
    input  logic       clk,
    input  logic       i_rst,
    input  logic [1:0] i_sync,
    input  logic       i_vld,
    output logic       o_block_lock
);
    import pcs_rx_pkg::*;

    localparam int CNT_W = $clog2((`PCS_LOCK_GOOD_CNT > `PCS_BAD_SH_WINDOW) ?
                                  `PCS_LOCK_GOOD_CNT : `PCS_BAD_SH_WINDOW);
    localparam int BAD_W = $clog2(`PCS_BAD_SH_MAX);

    localparam logic [CNT_W-1:0] GOOD_LAST = CNT_W'(`PCS_LOCK_GOOD_CNT - 1);
    localparam logic [CNT_W-1:0] WIN_LAST  = CNT_W'(`PCS_BAD_SH_WINDOW - 1);
    localparam logic [BAD_W-1:0] BAD_LAST  = BAD_W'(`PCS_BAD_SH_MAX - 1);

    logic [CNT_W-1:0] hdr_cnt;  // good run while unlocked, window slot while locked
    logic [BAD_W-1:0] bad_cnt;  // invalid headers in current window
    logic             sh_valid;

    assign sh_valid = (i_sync == SYNC_DATA) || (i_sync == SYNC_CTRL);

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_block_lock <= 1'b0;
            hdr_cnt      <= '0;
            bad_cnt      <= '0;
        end else if (i_vld) begin
            if (!o_block_lock) begin
                if (!sh_valid) begin
                    hdr_cnt <= '0;  // run broken, start over
                end else if (hdr_cnt == GOOD_LAST) begin
                    o_block_lock <= 1'b1;
                    hdr_cnt      <= '0;  // first window starts with next header
                end else begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                end
            end else begin
                if (!sh_valid && (bad_cnt == BAD_LAST)) begin
                    o_block_lock <= 1'b0;  // limit hit, back to searching
                    hdr_cnt      <= '0;
                    bad_cnt      <= '0;
                end else if (hdr_cnt == WIN_LAST) begin
                    hdr_cnt <= '0;  // window done below limit
                    bad_cnt <= '0;
                end else begin
                    hdr_cnt <= hdr_cnt + 1'b1;
                    if (!sh_valid) begin
                        bad_cnt <= bad_cnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- logic/pcs_descrambler.sv
// Self-synchronizing descrambler for x^58 + x^39 + 1, one block per cycle.
// The sync header is not scrambled and is only delayed next to its word.
`include "pcs_rx_params.svh"

module pcs_descrambler (
    input  logic                   clk,
    input  logic                   i_rst,
    input  pcs_rx_pkg::pcs_block_u i_data,
    input  logic [1:0]             i_sync,
    input  logic                   i_vld,
    output pcs_rx_pkg::pcs_block_u o_data,
    output logic [1:0]             o_sync,
    output logic                   o_vld
);
    import pcs_rx_pkg::*;

    localparam int HIST_W = `PCS_SCR_TAP_B;

    logic [HIST_W-1:0]    scr_hist;  // last received scrambled bits, msb newest
    logic [HIST_W+63:0]   stream;    // history below, current word on top
    logic [63:0]          descr;

    // bit i of the word sits at stream[HIST_W + i]
    always_comb begin
        stream = {i_data, scr_hist};
        for (int i = 0; i < 64; i++) begin
            descr[i] = stream[HIST_W + i]
                     ^ stream[HIST_W + i - `PCS_SCR_TAP_A]
                     ^ stream[HIST_W + i - `PCS_SCR_TAP_B];
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            scr_hist <= '0;
            o_vld    <= 1'b0;
        end else begin
            o_vld <= i_vld;
            if (i_vld) begin
                scr_hist <= stream[HIST_W+63 -: HIST_W];  // keep newest 58 bits
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            o_data <= descr;
            o_sync <= i_sync;
        end
    end

endmodule

//--- decoder/pcs_decoder.sv
// 64b/66b block decoder. Control blocks are rebuilt into eight lanes from the
// type byte, data blocks pass through; outputs are registered on the strobe.
module pcs_decoder (
    input  logic                   clk,
    input  logic                   i_rst,
    input  pcs_rx_pkg::pcs_block_u i_data,
    input  logic [1:0]             i_sync,
    input  logic                   i_vld,
    output pcs_rx_pkg::pcs_block_u o_data,
    output logic [7:0]             o_ctl,
    output logic                   o_vld
);
    import pcs_rx_pkg::*;

    logic [7:0][7:0] dec_lanes;  // lane 7 in the top byte
    logic [7:0]      dec_mask;   // bit k set marks lane k as control

    always_comb begin
        if (i_sync == SYNC_CTRL) begin
            case (i_data.ctl.type_code)
                TYPE_C8: begin
                    dec_lanes = {8{CHAR_IDLE}};
                    dec_mask  = 8'b1111_1111;
                end
                TYPE_C4_S: begin
                    dec_lanes = {{4{CHAR_IDLE}}, CHAR_START, i_data.bytes[2:0]};
                    dec_mask  = 8'b1111_1000;
                end
                TYPE_S_D7: begin
                    dec_lanes = {CHAR_START, i_data.bytes[6:0]};
                    dec_mask  = 8'b1000_0000;
                end
                TYPE_T0: begin
                    dec_lanes = {CHAR_TERM, {7{CHAR_IDLE}}};
                    dec_mask  = 8'b1111_1111;
                end
                TYPE_T1: begin
                    dec_lanes = {i_data.bytes[6], CHAR_TERM, {6{CHAR_IDLE}}};
                    dec_mask  = 8'b0111_1111;
                end
                TYPE_T2: begin
                    dec_lanes = {i_data.bytes[6:5], CHAR_TERM, {5{CHAR_IDLE}}};
                    dec_mask  = 8'b0011_1111;
                end
                TYPE_T3: begin
                    dec_lanes = {i_data.bytes[6:4], CHAR_TERM, {4{CHAR_IDLE}}};
                    dec_mask  = 8'b0001_1111;
                end
                TYPE_T4: begin
                    dec_lanes = {i_data.bytes[6:3], CHAR_TERM, {3{CHAR_IDLE}}};
                    dec_mask  = 8'b0000_1111;
                end
                TYPE_T5: begin
                    dec_lanes = {i_data.bytes[6:2], CHAR_TERM, {2{CHAR_IDLE}}};
                    dec_mask  = 8'b0000_0111;
                end
                TYPE_T6: begin
                    dec_lanes = {i_data.bytes[6:1], CHAR_TERM, CHAR_IDLE};
                    dec_mask  = 8'b0000_0011;
                end
                TYPE_T7: begin
                    dec_lanes = {i_data.bytes[6:0], CHAR_TERM};
                    dec_mask  = 8'b0000_0001;
                end
                TYPE_O_C4: begin
                    dec_lanes = {CHAR_SEQ, i_data.bytes[6:4], {4{CHAR_IDLE}}};
                    dec_mask  = 8'b1000_1111;
                end
                TYPE_C4_O: begin
                    dec_lanes = {{4{CHAR_IDLE}}, CHAR_SEQ, i_data.bytes[2:0]};
                    dec_mask  = 8'b1111_1000;
                end
                TYPE_O_S: begin
                    dec_lanes = {CHAR_SEQ, i_data.bytes[6:4],
                                 CHAR_START, i_data.bytes[2:0]};
                    dec_mask  = 8'b1000_1000;
                end
                TYPE_O_O: begin
                    dec_lanes = {CHAR_SEQ, i_data.bytes[6:4],
                                 CHAR_SEQ, i_data.bytes[2:0]};
                    dec_mask  = 8'b1000_1000;
                end
                default: begin
                    dec_lanes = '0;  // unknown type code
                    dec_mask  = '0;
                end
            endcase
        end else begin
            // data header, or an invalid one, goes through untouched
            dec_lanes = i_data.bytes;
            dec_mask  = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_vld <= 1'b0;
        end else begin
            o_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (i_vld) begin
            o_data <= dec_lanes;
            o_ctl  <= dec_mask;
        end
    end

endmodule

//--- logic/pcs_rx_top.sv
// Receive PCS top: block lock monitor, descrambler and block decoder.
// A block accepted at one edge leaves o_data and o_ctl two edges later.
module pcs_rx_top (
    input  logic                   clk,
    input  logic                   i_rst,
    input  pcs_rx_pkg::pcs_block_u i_data,
    input  logic [1:0]             i_sync,
    input  logic                   i_vld,
    output pcs_rx_pkg::pcs_block_u o_data,
    output logic [7:0]             o_ctl,
    output logic                   o_vld,
    output logic                   o_block_lock
);
    import pcs_rx_pkg::*;

    pcs_block_u desc_data;  // descrambled word
    logic [1:0] desc_sync;  // header delayed with it
    logic       desc_vld;

    // lock watches the raw headers, not the delayed ones
    pcs_block_lock pcs_block_lock_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_sync       (i_sync),
        .i_vld        (i_vld),
        .o_block_lock (o_block_lock)
    );

    pcs_descrambler pcs_descrambler_i (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_data (i_data),
        .i_sync (i_sync),
        .i_vld  (i_vld),
        .o_data (desc_data),
        .o_sync (desc_sync),
        .o_vld  (desc_vld)
    );

    pcs_decoder pcs_decoder_i (
        .clk    (clk),
        .i_rst  (i_rst),
        .i_data (desc_data),
        .i_sync (desc_sync),
        .i_vld  (desc_vld),
        .o_data (o_data),
        .o_ctl  (o_ctl),
        .o_vld  (o_vld)
    );

endmodule

//--- verification/tb_clock_gen.sv
// Clock and reset source for the PCS receive testbench.
// 40 ns clock, reset held high for the first five rising edges.
module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;  // 40 ns period
    end

    initial begin
        o_rst = 1'b1;
        repeat (5) @(posedge o_clk);
        #2;
        o_rst = 1'b0;  // released at the usual drive offset
    end

endmodule

//--- verification/pcs_rx_tb.sv
// Testbench for the PCS receive top: scrambles known blocks, predicts lanes,
// mask and block lock from the decoding and lock rules, and checks them.
`include "pcs_rx_params.svh"

module pcs_rx_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import pcs_rx_pkg::*;

    localparam int N_DATA      = 120;
    localparam int N_CTRL_REPS = 4;
    // block slots of all tests, gaps and flushes included
    localparam int TEST_CYCLES = 10 + 3 * N_DATA + 15 * N_CTRL_REPS + 24 + 400 + 130 + 24;

    logic       clk;
    logic       i_rst;
    pcs_block_u i_data;
    logic [1:0] i_sync;
    logic       i_vld;
    pcs_block_u o_data;
    logic [7:0] o_ctl;
    logic       o_vld;
    logic       o_block_lock;

    integer      seed = 32'h4f68_4c1b;
    logic [57:0] scr_sr = '0;      // reference scrambler, index 0 is the newest bit
    logic [71:0] exp_q [$];        // expected {lanes, mask} in send order
    logic [63:0] exp_data = '0;
    logic [7:0]  exp_ctl = '0;
    logic        exp_present = 1'b1;
    logic        exp_lock = 1'b0;
    int          good_run = 0;
    int          win_cnt = 0;
    int          bad_cnt = 0;
    logic        rst_seen = 1'b0;
    logic        vld_d1 = 1'b0;
    logic        vld_d2 = 1'b0;
    int          errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [7:0]  ctl_codes [15] = '{8'h1e, 8'h33, 8'h78, 8'h87, 8'h99, 8'haa, 8'hb4, 8'hcc,
                                    8'hd2, 8'he1, 8'hff, 8'h4b, 8'h2d, 8'h66, 8'h55};
    logic [7:0]  bad_codes [8] = '{8'h00, 8'h11, 8'h5a, 8'hf0, 8'h1f, 8'h3c, 8'h96, 8'hc3};

    tb_clock_gen tb_clock_gen_i (
        .o_clk (clk),
        .o_rst (i_rst)
    );

    pcs_rx_top pcs_rx_top_i (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_data       (i_data),
        .i_sync       (i_sync),
        .i_vld        (i_vld),
        .o_data       (o_data),
        .o_ctl        (o_ctl),
        .o_vld        (o_vld),
        .o_block_lock (o_block_lock)
    );

    always @(posedge clk) begin
        rst_seen <= i_rst;
        vld_d1   <= i_vld;
        vld_d2   <= vld_d1;  // strobe two edges back
    end

    // take the next expected block as soon as an output block shows up
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (o_vld === 1'b1) begin
                if (exp_q.size() > 0) begin
                    {exp_data, exp_ctl} = exp_q.pop_front();
                    exp_present = 1'b1;
                end else begin
                    exp_present = 1'b0;
                end
            end
        end
    end

    rst_vld_check: assert property (@(posedge clk) rst_seen |-> !o_vld)
        else begin
            errors++;
            $display("FAIL t=%0t o_vld expected 0 actual %b", $time, $sampled(o_vld));
        end

    rst_lock_check: assert property (@(posedge clk) rst_seen |-> !o_block_lock)
        else begin
            errors++;
            $display("FAIL t=%0t o_block_lock expected 0 actual %b", $time,
                     $sampled(o_block_lock));
        end

    latency_check: assert property (@(posedge clk) disable iff (i_rst) o_vld == vld_d2)
        else begin
            errors++;
            $display("FAIL t=%0t o_vld expected %b actual %b", $time, $sampled(vld_d2),
                     $sampled(o_vld));
        end

    present_check: assert property (@(posedge clk) disable iff (i_rst) o_vld |-> exp_present)
        else begin
            errors++;
            $display("output block at t=%0t arrived with no block sent for it", $time);
        end

    data_check: assert property (@(posedge clk) disable iff (i_rst)
                                 (o_vld && exp_present) |-> (o_data == exp_data))
        else begin
            errors++;
            $display("FAIL t=%0t o_data expected %h actual %h", $time, $sampled(exp_data),
                     $sampled(o_data));
        end

    ctl_check: assert property (@(posedge clk) disable iff (i_rst)
                                (o_vld && exp_present) |-> (o_ctl == exp_ctl))
        else begin
            errors++;
            $display("FAIL t=%0t o_ctl expected %h actual %h", $time, $sampled(exp_ctl),
                     $sampled(o_ctl));
        end

    lock_check: assert property (@(posedge clk) disable iff (i_rst) o_block_lock == exp_lock)
        else begin
            errors++;
            $display("FAIL t=%0t o_block_lock expected %b actual %b", $time,
                     $sampled(exp_lock), $sampled(o_block_lock));
        end

    // lanes and mask that the decoding table gives for a plain word
    function automatic logic [71:0] expected_lanes(input logic [63:0] w, input logic [1:0] sh);
        logic [7:0]  lane [8];
        logic [7:0]  mask;
        logic [63:0] flat;
        int          n;
        int          k;
        for (k = 0; k < 8; k++) begin
            lane[k] = w[8*k +: 8];  // payload keeps its byte position
        end
        mask = 8'h00;
        n    = -1;
        if (sh == 2'b10) begin
            case (w[63:56])
                8'h1e: begin
                    for (k = 0; k < 8; k++) begin
                        lane[k] = 8'h07;
                    end
                    mask = 8'hff;
                end
                8'h33, 8'h2d: begin
                    for (k = 4; k < 8; k++) begin
                        lane[k] = 8'h07;
                    end
                    lane[3] = (w[63:56] == 8'h33) ? 8'hfb : 8'h9c;
                    mask    = 8'hf8;
                end
                8'h78: begin
                    lane[7] = 8'hfb;
                    mask    = 8'h80;
                end
                8'h87: n = 0;
                8'h99: n = 1;
                8'haa: n = 2;
                8'hb4: n = 3;
                8'hcc: n = 4;
                8'hd2: n = 5;
                8'he1: n = 6;
                8'hff: n = 7;
                8'h4b: begin
                    lane[7] = 8'h9c;
                    for (k = 0; k < 4; k++) begin
                        lane[k] = 8'h07;
                    end
                    mask = 8'h8f;
                end
                8'h66, 8'h55: begin
                    lane[7] = 8'h9c;
                    lane[3] = (w[63:56] == 8'h66) ? 8'hfb : 8'h9c;
                    mask    = 8'h88;
                end
                default: begin
                    for (k = 0; k < 8; k++) begin
                        lane[k] = 8'h00;
                    end
                end
            endcase
            if (n >= 0) begin
                for (k = 0; k < 8; k++) begin  // n data lanes, terminate, idles
                    if (k > 7 - n) begin
                        lane[k] = w[8*(k-1) +: 8];
                    end else if (k == 7 - n) begin
                        lane[k] = 8'hfd;
                    end else begin
                        lane[k] = 8'h07;
                    end
                    mask[k] = (k <= 7 - n);
                end
            end
        end
        for (k = 0; k < 8; k++) begin
            flat[8*k +: 8] = lane[k];
        end
        return {flat, mask};
    endfunction

    function automatic logic [63:0] random_word();
        return {$random(seed), $random(seed)};
    endfunction

    // serial x^58 + x^39 + 1 scrambler, bit 0 goes first
    task automatic scramble_block(input logic [63:0] plain, output logic [63:0] scr);
        int b;
        for (b = 0; b < 64; b++) begin
            scr[b] = plain[b] ^ scr_sr[`PCS_SCR_TAP_A-1] ^ scr_sr[`PCS_SCR_TAP_B-1];
            scr_sr = {scr_sr[56:0], scr[b]};
        end
    endtask

    task automatic step_lock_model(input logic [1:0] sh);
        logic valid;
        valid = (sh == 2'b01) || (sh == 2'b10);
        if (!exp_lock) begin
            good_run = valid ? good_run + 1 : 0;
            if (good_run == `PCS_LOCK_GOOD_CNT) begin
                exp_lock = 1'b1;
                good_run = 0;
                win_cnt  = 0;
                bad_cnt  = 0;
            end
        end else begin
            win_cnt++;
            if (!valid) begin
                bad_cnt++;
            end
            if (bad_cnt == `PCS_BAD_SH_MAX) begin
                exp_lock = 1'b0;  // too many bad headers in this window
                win_cnt  = 0;
                bad_cnt  = 0;
            end else if (win_cnt == `PCS_BAD_SH_WINDOW) begin
                win_cnt = 0;
                bad_cnt = 0;
            end
        end
    endtask

    task automatic send_block(input logic [63:0] plain, input logic [1:0] sh);
        logic [63:0] scr;
        exp_q.push_back(expected_lanes(plain, sh));
        scramble_block(plain, scr);
        i_data = scr;
        i_sync = sh;
        i_vld  = 1'b1;
        @(posedge clk);
        #2;
        i_vld = 1'b0;
        step_lock_model(sh);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_lock_state(input logic expected);
        assert (o_block_lock == expected)
            else begin
                errors++;
                $display("FAIL t=%0t o_block_lock expected %b actual %b", $time, expected,
                         o_block_lock);
            end
    endtask

    task automatic close_test(input string name, input int errs_before);
        idle_cycles(4);  // drain both pipeline stages
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int start_errs;
        int gap;
        int guard;
        int nbad;
        i_data = '0;
        i_sync = 2'b00;
        i_vld  = 1'b0;
        start_errs = errors;
        @(negedge i_rst);
        close_test("1 reset", start_errs);

        start_errs = errors;
        for (int i = 0; i < N_DATA; i++) begin
            send_block(random_word(), 2'b01);
            gap = {$random(seed)} % 3;  // idle cycles must not move the history
            idle_cycles(gap);
        end
        close_test("2 data blocks", start_errs);

        start_errs = errors;
        for (int r = 0; r < N_CTRL_REPS; r++) begin
            for (int c = 0; c < 15; c++) begin
                send_block({ctl_codes[c], 56'(random_word())}, 2'b10);
            end
        end
        close_test("3 control blocks", start_errs);

        start_errs = errors;
        for (int c = 0; c < 8; c++) begin
            send_block({bad_codes[c], 56'(random_word())}, 2'b10);
        end
        for (int i = 0; i < 16; i++) begin
            send_block(random_word(), (i % 2 == 0) ? 2'b00 : 2'b11);
        end
        close_test("4 unknown codes and bad headers", start_errs);

        start_errs = errors;
        guard = 0;
        while (exp_lock && guard < 200) begin  // leave any lock from earlier tests
            send_block(random_word(), 2'b00);
            guard++;
        end
        send_block(random_word(), 2'b11);
        for (int i = 0; i < 30; i++) begin
            send_block(random_word(), 2'b01);
        end
        send_block(random_word(), 2'b00);  // restarts the good run
        for (int i = 0; i < `PCS_LOCK_GOOD_CNT - 1; i++) begin
            send_block(random_word(), 2'b01);
        end
        check_lock_state(1'b0);
        send_block(random_word(), 2'b01);
        check_lock_state(1'b1);
        close_test("5 lock acquire", start_errs);

        start_errs = errors;
        for (int i = 0; i < `PCS_BAD_SH_WINDOW; i++) begin
            send_block(random_word(), (i % 4 == 1 && i < 60) ? 2'b00 : 2'b01);  // 15 bad
        end
        check_lock_state(1'b1);
        nbad = 0;
        for (int i = 0; nbad < `PCS_BAD_SH_MAX; i++) begin
            if (i % 3 == 0) begin
                check_lock_state(1'b1);
                send_block(random_word(), 2'b11);
                nbad++;
            end else begin
                send_block(random_word(), 2'b01);
            end
        end
        check_lock_state(1'b0);
        for (int i = 0; i < 8; i++) begin
            send_block(random_word(), 2'b01);
        end
        close_test("6 lock loss", start_errs);

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 100) * 40);
        $display("run timed out at t=%0t before all tests finished", $time);
        $display("TB FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/pcs_rx_pkg.sv
logic/pcs_block_lock.sv
logic/pcs_descrambler.sv
decoder/pcs_decoder.sv
logic/pcs_rx_top.sv
verification/tb_clock_gen.sv
verification/pcs_rx_tb.sv
